/* saturn_pkg.sv */
// shared widths, operation and state enums, and packed records for the saturn decode core.
package saturn_pkg;

    // ====================
    // widths
    // ====================

    localparam int NIB_W    = 4;
    localparam int ADDR_W   = 20;
    localparam int REG_NIBS = 16;

    typedef logic [NIB_W-1:0]          nib_t;
    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [REG_NIBS*NIB_W-1:0] word_t;

    // ====================
    // enums
    // ====================

    // seventeen operations need a five bit code.
    typedef enum logic [4:0] {
        OP_RTNSC,
        OP_RTNCC,
        OP_SETHEX,
        OP_SETDEC,
        OP_D0_IMM,
        OP_P_IMM,
        OP_LC,
        OP_GOTO,
        OP_CONFIG,
        OP_RESET,
        OP_C_EQ_P,
        OP_HST_CLR,
        OP_ST_CLR,
        OP_ST_SET,
        OP_GOVLNG,
        OP_GOSBVL,
        OP_ILLEGAL
    } op_e;

    // decoder position inside the opcode tree.
    typedef enum logic [3:0] {
        S_FIRST,
        S_BLK0,
        S_BLK1,
        S_BLK8,
        S_BLK80,
        S_ARG,
        S_IMM
    } dec_state_e;

    // ====================
    // records
    // ====================

    // one decoded instruction.
    // imm holds the first immediate nibble in its lowest nibble.
    // len is five bits wide because LC can reach 18 nibbles.
    typedef struct packed {
        op_e        op;
        addr_t      pc;
        word_t      imm;
        nib_t       arg;
        logic [4:0] len;
    } uop_t;

    // one retired instruction.
    typedef struct packed {
        op_e   op;
        addr_t pc;
        word_t value;
        addr_t next_pc;
    } ret_t;

endpackage

/* saturn_decode.sv */
// nibble-serial opcode decoder that collects each instruction into one micro-operation.
`timescale 1ns/1ps

module saturn_decode (
    input  logic              i_clk,
    input  logic              i_reset,
    input  saturn_pkg::nib_t  i_nib,
    input  logic              i_nib_valid,
    output logic              o_nib_ready,
    output saturn_pkg::uop_t  o_uop,
    output logic              o_uop_valid,
    input  logic              i_uop_ready
);

    saturn_pkg::dec_state_e state_q;
    saturn_pkg::dec_state_e state_d;
    saturn_pkg::addr_t      nib_pc_q;
    saturn_pkg::addr_t      start_pc_q;
    saturn_pkg::addr_t      cur_pc;
    saturn_pkg::op_e        op_q;
    saturn_pkg::op_e        op_d;
    saturn_pkg::op_e        done_op;
    saturn_pkg::nib_t       arg_q;
    saturn_pkg::nib_t       arg_d;
    saturn_pkg::word_t      imm_q;
    saturn_pkg::word_t      imm_next;
    saturn_pkg::uop_t       uop_q;
    saturn_pkg::uop_t       uop_d;
    logic [4:0]             len_q;
    logic [4:0]             cur_len;
    logic [4:0]             imm_cnt_q;
    logic [4:0]             imm_need_q;
    logic [4:0]             need_d;
    logic                   uop_valid_q;
    logic                   nib_acc;
    logic                   done;

    // a new nibble is taken unless a finished uop is stuck downstream.
    assign o_nib_ready = !uop_valid_q || i_uop_ready;
    assign nib_acc     = i_nib_valid && o_nib_ready;
    assign o_uop       = uop_q;
    assign o_uop_valid = uop_valid_q;

    assign cur_pc   = (state_q == saturn_pkg::S_FIRST) ? nib_pc_q : start_pc_q;
    assign cur_len  = len_q + 5'd1;
    assign imm_next = imm_q | (saturn_pkg::word_t'(i_nib) << {imm_cnt_q, 2'b00});

    assign uop_d.op  = done_op;
    assign uop_d.pc  = cur_pc;
    assign uop_d.imm = (state_q == saturn_pkg::S_IMM) ? imm_next : imm_q;
    assign uop_d.arg = arg_d;
    assign uop_d.len = (done_op == saturn_pkg::OP_ILLEGAL) ? 5'd1 : cur_len;

    // ====================
    // opcode tree
    // ====================

    always_comb begin
        state_d  = state_q;
        op_d     = op_q;
        arg_d    = arg_q;
        need_d   = imm_need_q;
        done     = 1'b0;
        done_op  = saturn_pkg::OP_ILLEGAL;
        case (state_q)
            saturn_pkg::S_FIRST: begin
                case (i_nib)
                    4'h0: state_d = saturn_pkg::S_BLK0;
                    4'h1: state_d = saturn_pkg::S_BLK1;
                    4'h2: begin
                        state_d = saturn_pkg::S_ARG;
                        op_d    = saturn_pkg::OP_P_IMM;
                    end
                    4'h3: begin
                        state_d = saturn_pkg::S_ARG;
                        op_d    = saturn_pkg::OP_LC;
                    end
                    4'h6: begin
                        state_d = saturn_pkg::S_IMM;
                        op_d    = saturn_pkg::OP_GOTO;
                        need_d  = 5'd3;
                    end
                    4'h8: state_d = saturn_pkg::S_BLK8;
                    default: done = 1'b1;
                endcase
            end
            saturn_pkg::S_BLK0: begin
                done = 1'b1;
                case (i_nib)
                    4'h2: done_op = saturn_pkg::OP_RTNSC;
                    4'h3: done_op = saturn_pkg::OP_RTNCC;
                    4'h4: done_op = saturn_pkg::OP_SETHEX;
                    4'h5: done_op = saturn_pkg::OP_SETDEC;
                    default: done_op = saturn_pkg::OP_ILLEGAL;
                endcase
            end
            saturn_pkg::S_BLK1: begin
                if (i_nib == 4'hB) begin
                    state_d = saturn_pkg::S_IMM;
                    op_d    = saturn_pkg::OP_D0_IMM;
                    need_d  = 5'd5;
                end else begin
                    done = 1'b1;
                end
            end
            saturn_pkg::S_BLK8: begin
                state_d = saturn_pkg::S_ARG;
                need_d  = 5'd5;
                case (i_nib)
                    4'h0: state_d = saturn_pkg::S_BLK80;
                    4'h2: op_d = saturn_pkg::OP_HST_CLR;
                    4'h4: op_d = saturn_pkg::OP_ST_CLR;
                    4'h5: op_d = saturn_pkg::OP_ST_SET;
                    4'hD: begin
                        state_d = saturn_pkg::S_IMM;
                        op_d    = saturn_pkg::OP_GOVLNG;
                    end
                    4'hF: begin
                        state_d = saturn_pkg::S_IMM;
                        op_d    = saturn_pkg::OP_GOSBVL;
                    end
                    default: done = 1'b1;
                endcase
            end
            saturn_pkg::S_BLK80: begin
                case (i_nib)
                    4'h5: begin
                        done    = 1'b1;
                        done_op = saturn_pkg::OP_CONFIG;
                    end
                    4'hA: begin
                        done    = 1'b1;
                        done_op = saturn_pkg::OP_RESET;
                    end
                    4'hC: begin
                        state_d = saturn_pkg::S_ARG;
                        op_d    = saturn_pkg::OP_C_EQ_P;
                    end
                    default: done = 1'b1;
                endcase
            end
            saturn_pkg::S_ARG: begin
                arg_d    = i_nib;
                done_op  = op_q;
                if (op_q == saturn_pkg::OP_LC) begin
                    // LC n is followed by n+1 data nibbles.
                    state_d = saturn_pkg::S_IMM;
                    need_d  = {1'b0, i_nib} + 5'd1;
                end else begin
                    done = 1'b1;
                end
            end
            saturn_pkg::S_IMM: begin
                done_op = op_q;
                done    = (imm_cnt_q + 5'd1 == imm_need_q);
            end
            default: done = 1'b1;
        endcase
        if (done) begin
            state_d = saturn_pkg::S_FIRST;
        end
    end

    // ====================
    // registers
    // ====================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q     <= saturn_pkg::S_FIRST;
            nib_pc_q    <= '0;
            len_q       <= '0;
            imm_cnt_q   <= '0;
            imm_q       <= '0;
            arg_q       <= '0;
            uop_valid_q <= 1'b0;
        end else begin
            if (uop_valid_q && i_uop_ready) begin
                uop_valid_q <= 1'b0;
            end
            if (nib_acc) begin
                nib_pc_q <= nib_pc_q + 20'd1;
                state_q  <= state_d;
                if (done) begin
                    uop_valid_q <= 1'b1;
                    len_q       <= '0;
                    imm_cnt_q   <= '0;
                    imm_q       <= '0;
                    arg_q       <= '0;
                end else begin
                    len_q <= cur_len;
                    arg_q <= arg_d;
                    if (state_q == saturn_pkg::S_IMM) begin
                        imm_q     <= imm_next;
                        imm_cnt_q <= imm_cnt_q + 5'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (nib_acc) begin
            op_q       <= op_d;
            imm_need_q <= need_d;
            if (state_q == saturn_pkg::S_FIRST) begin
                start_pc_q <= nib_pc_q;
            end
            if (done) begin
                uop_q <= uop_d;
            end
        end
    end

endmodule

/* saturn_exec.sv */
// single-cycle execute stage with the architectural register model and the return stack.
`timescale 1ns/1ps

module saturn_exec #(
    parameter int RSTK_DEPTH = 8
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  saturn_pkg::uop_t  i_uop,
    input  logic              i_uop_valid,
    output logic              o_uop_ready,
    output saturn_pkg::ret_t  o_ret,
    output logic              o_ret_valid,
    input  logic              i_ret_ready
);

    localparam int CNT_W = $clog2(RSTK_DEPTH + 1);

    saturn_pkg::nib_t  p_q;
    saturn_pkg::nib_t  p_d;
    saturn_pkg::word_t c_q;
    saturn_pkg::word_t c_d;
    saturn_pkg::word_t c_lc;
    saturn_pkg::word_t c_cp;
    saturn_pkg::addr_t d0_q;
    saturn_pkg::addr_t d0_d;
    saturn_pkg::addr_t rstk [RSTK_DEPTH];
    saturn_pkg::addr_t pop_val;
    saturn_pkg::addr_t seq_pc;
    saturn_pkg::addr_t goto_pc;
    saturn_pkg::addr_t next_pc;
    saturn_pkg::word_t value;
    logic [15:0]       st_q;
    logic [15:0]       st_d;
    logic [3:0]        hst_q;
    logic [3:0]        hst_d;
    logic [CNT_W-1:0]  rstk_cnt_q;
    logic              carry_q;
    logic              carry_d;
    logic              hex_q;
    logic              hex_d;
    logic              push;
    logic              pop;
    logic              xfer;

    assign o_uop_ready = i_ret_ready;
    assign o_ret_valid = i_uop_valid;
    assign xfer        = i_uop_valid && i_ret_ready;

    assign pop_val = (rstk_cnt_q == '0) ? '0 : rstk[0];
    assign seq_pc  = i_uop.pc + saturn_pkg::addr_t'(i_uop.len);
    // GOTO offset is relative to the nibble after the 6.
    assign goto_pc = i_uop.pc + 20'd1 + {{8{i_uop.imm[11]}}, i_uop.imm[11:0]};

    assign o_ret.op      = i_uop.op;
    assign o_ret.pc      = i_uop.pc;
    assign o_ret.value   = value;
    assign o_ret.next_pc = next_pc;

    // LC writes n+1 nibbles of C from nibble P upward, wrapping at 16.
    always_comb begin
        saturn_pkg::nib_t idx;
        c_lc = c_q;
        for (int i = 0; i < saturn_pkg::REG_NIBS; i++) begin
            idx = p_q + saturn_pkg::nib_t'(i);
            if (i <= int'(i_uop.arg)) begin
                c_lc[{idx, 2'b00} +: 4] = i_uop.imm[4*i +: 4];
            end
        end
        c_cp = c_q;
        c_cp[{i_uop.arg, 2'b00} +: 4] = p_q;
    end

    // ====================
    // operation rules
    // ====================

    always_comb begin
        p_d     = p_q;
        c_d     = c_q;
        d0_d    = d0_q;
        st_d    = st_q;
        hst_d   = hst_q;
        carry_d = carry_q;
        hex_d   = hex_q;
        push    = 1'b0;
        pop     = 1'b0;
        value   = '0;
        next_pc = seq_pc;
        case (i_uop.op)
            saturn_pkg::OP_P_IMM: begin
                p_d   = i_uop.arg;
                value = {60'b0, i_uop.arg};
            end
            saturn_pkg::OP_LC: begin
                c_d   = c_lc;
                value = c_lc;
            end
            saturn_pkg::OP_C_EQ_P: begin
                c_d   = c_cp;
                value = c_cp;
            end
            saturn_pkg::OP_D0_IMM: begin
                d0_d  = i_uop.imm[19:0];
                value = {44'b0, i_uop.imm[19:0]};
            end
            saturn_pkg::OP_ST_CLR, saturn_pkg::OP_ST_SET: begin
                st_d[i_uop.arg] = (i_uop.op == saturn_pkg::OP_ST_SET);
                value           = {48'b0, st_d};
            end
            saturn_pkg::OP_HST_CLR: begin
                hst_d = hst_q & ~i_uop.arg;
                value = {60'b0, hst_d};
            end
            saturn_pkg::OP_SETHEX: begin
                hex_d = 1'b1;
                value = 64'd1;
            end
            saturn_pkg::OP_SETDEC: begin
                hex_d = 1'b0;
            end
            saturn_pkg::OP_RTNSC, saturn_pkg::OP_RTNCC: begin
                carry_d = (i_uop.op == saturn_pkg::OP_RTNSC);
                pop     = 1'b1;
                value   = {63'b0, carry_d};
                next_pc = pop_val;
            end
            saturn_pkg::OP_GOTO: next_pc = goto_pc;
            saturn_pkg::OP_GOVLNG: next_pc = i_uop.imm[19:0];
            saturn_pkg::OP_GOSBVL: begin
                next_pc = i_uop.imm[19:0];
                push    = 1'b1;
            end
            default: value = '0;
        endcase
    end

    // ====================
    // state update
    // ====================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            p_q        <= '0;
            c_q        <= '0;
            d0_q       <= '0;
            st_q       <= '0;
            hst_q      <= '0;
            carry_q    <= 1'b0;
            hex_q      <= 1'b1;
            rstk_cnt_q <= '0;
        end else if (xfer) begin
            p_q     <= p_d;
            c_q     <= c_d;
            d0_q    <= d0_d;
            st_q    <= st_d;
            hst_q   <= hst_d;
            carry_q <= carry_d;
            hex_q   <= hex_d;
            if (push && rstk_cnt_q != CNT_W'(RSTK_DEPTH)) begin
                rstk_cnt_q <= rstk_cnt_q + 1'b1;
            end else if (pop && rstk_cnt_q != '0) begin
                rstk_cnt_q <= rstk_cnt_q - 1'b1;
            end
        end
    end

    // top of stack is entry 0; a push into a full stack drops the bottom.
    always_ff @(posedge i_clk) begin
        if (xfer && push) begin
            rstk[0] <= i_uop.pc + 20'd7;
            for (int i = 1; i < RSTK_DEPTH; i++) begin
                rstk[i] <= rstk[i-1];
            end
        end else if (xfer && pop) begin
            for (int i = 0; i < RSTK_DEPTH - 1; i++) begin
                rstk[i] <= rstk[i+1];
            end
        end
    end

endmodule

/* saturn_retire.sv */
// one-entry retire register that holds each record until the consumer reads it.
`timescale 1ns/1ps

module saturn_retire (
    input  logic              i_clk,
    input  logic              i_reset,
    input  saturn_pkg::ret_t  i_ret,
    input  logic              i_ret_valid,
    output logic              o_ret_ready,
    output saturn_pkg::ret_t  o_ret,
    output logic              o_ret_valid,
    input  logic              i_out_ready
);

    saturn_pkg::ret_t ret_q;
    logic             valid_q;
    logic             load;

    // free when empty or when the held record leaves this cycle.
    assign o_ret_ready = !valid_q || i_out_ready;
    assign load        = i_ret_valid && o_ret_ready;
    assign o_ret       = ret_q;
    assign o_ret_valid = valid_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (i_out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            ret_q <= i_ret;
        end
    end

endmodule

/* saturn_core.sv */
// top level of the nibble decoder core, chaining decode, execute and retire.
`timescale 1ns/1ps

module saturn_core #(
    parameter int RSTK_DEPTH = 8
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  saturn_pkg::nib_t  i_nib,
    input  logic              i_nib_valid,
    output logic              o_nib_ready,
    output saturn_pkg::ret_t  o_ret,
    output logic              o_ret_valid,
    input  logic              i_ret_ready
);

    saturn_pkg::uop_t uop;
    saturn_pkg::ret_t exec_ret;
    logic             uop_valid;
    logic             uop_ready;
    logic             exec_ret_valid;
    logic             exec_ret_ready;

    saturn_decode saturn_decode_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_nib       (i_nib),
        .i_nib_valid (i_nib_valid),
        .o_nib_ready (o_nib_ready),
        .o_uop       (uop),
        .o_uop_valid (uop_valid),
        .i_uop_ready (uop_ready)
    );

    saturn_exec #(
        .RSTK_DEPTH (RSTK_DEPTH)
    ) saturn_exec_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_uop       (uop),
        .i_uop_valid (uop_valid),
        .o_uop_ready (uop_ready),
        .o_ret       (exec_ret),
        .o_ret_valid (exec_ret_valid),
        .i_ret_ready (exec_ret_ready)
    );

    saturn_retire saturn_retire_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_ret       (exec_ret),
        .i_ret_valid (exec_ret_valid),
        .o_ret_ready (exec_ret_ready),
        .o_ret       (o_ret),
        .o_ret_valid (o_ret_valid),
        .i_out_ready (i_ret_ready)
    );

endmodule

/* saturn_core_sva.sv */
// handshake and reset assertions for the saturn core, attached to the top level with bind.
`timescale 1ns/1ps

module saturn_core_sva (
    input logic             i_clk,
    input logic             i_reset,
    input logic             i_nib_valid,
    input logic             o_nib_ready,
    input saturn_pkg::ret_t o_ret,
    input logic             o_ret_valid,
    input logic             i_ret_ready
);

    logic seen_acc_q;

    // set once any nibble has been accepted since reset.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            seen_acc_q <= 1'b0;
        end else if (i_nib_valid && o_nib_ready) begin
            seen_acc_q <= 1'b1;
        end
    end

    ret_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_ret_valid && !i_ret_ready) |=> (o_ret_valid && $stable(o_ret)))
        else $error("retire record changed while the consumer stalled");

    reset_clears_valid: assert property (@(posedge i_clk) i_reset |=> !o_ret_valid)
        else $error("retire valid high in the cycle after reset");

    valid_needs_input: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_ret_valid) |-> seen_acc_q)
        else $error("retire valid rose before any nibble was accepted");

endmodule

bind saturn_core saturn_core_sva saturn_core_sva_i (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_nib_valid (i_nib_valid),
    .o_nib_ready (o_nib_ready),
    .o_ret       (o_ret),
    .o_ret_valid (o_ret_valid),
    .i_ret_ready (i_ret_ready)
);

/* tb_saturn_core.sv */
// testbench that replays the pattern file into the saturn core and checks each retire record.
`timescale 1ns/1ps

module tb_saturn_core;

    localparam int CLK_PERIOD = 10;

    logic              i_clk;
    logic              i_reset;
    saturn_pkg::nib_t  i_nib;
    logic              i_nib_valid;
    logic              o_nib_ready;
    saturn_pkg::ret_t  o_ret;
    logic              o_ret_valid;
    logic              i_ret_ready;

    saturn_pkg::nib_t  nib_q [$];
    saturn_pkg::ret_t  exp_q [$];
    logic [31:0]       lcg_state;
    int                pattern_lines;
    int                retired;
    logic              loaded;

    saturn_core saturn_core_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_nib       (i_nib),
        .i_nib_valid (i_nib_valid),
        .o_nib_ready (o_nib_ready),
        .o_ret       (o_ret),
        .o_ret_valid (o_ret_valid),
        .i_ret_ready (i_ret_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // ====================
    // helpers
    // ====================

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // true about one time in four.
    function automatic logic rand_stall();
        logic [31:0] r;
        r = next_rand();
        return r[31:30] == 2'b00;
    endfunction

    function automatic int hex_digit(int c);
        if (c >= "0" && c <= "9") begin
            return c - "0";
        end
        if (c >= "a" && c <= "f") begin
            return c - "a" + 10;
        end
        if (c >= "A" && c <= "F") begin
            return c - "A" + 10;
        end
        return -1;
    endfunction

    task automatic load_patterns();
        int               fd;
        int               c;
        int               d;
        int               n;
        logic [7:0]       op_v;
        logic [19:0]      pc_v;
        logic [63:0]      val_v;
        logic [19:0]      npc_v;
        saturn_pkg::ret_t rec;
        fd = $fopen("saturn_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file saturn_patterns.txt");
            $display("sim failed");
            $fatal(1, "pattern file missing");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "N") begin
                // one hex digit per nibble, in stream order.
                pattern_lines++;
                c = $fgetc(fd);
                while (c != -1 && c != "\n") begin
                    d = hex_digit(c);
                    if (d >= 0) begin
                        nib_q.push_back(saturn_pkg::nib_t'(d));
                    end
                    c = $fgetc(fd);
                end
            end else if (c == "E") begin
                pattern_lines++;
                n = $fscanf(fd, "%h %h %h %h", op_v, pc_v, val_v, npc_v);
                if (n != 4) begin
                    $display("malformed expected record in the pattern file");
                    $display("sim failed");
                    $fatal(1, "bad pattern line");
                end
                rec.op      = saturn_pkg::op_e'(op_v[4:0]);
                rec.pc      = pc_v;
                rec.value   = val_v;
                rec.next_pc = npc_v;
                exp_q.push_back(rec);
            end else if (c == "#") begin
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic report_mismatch(string field, logic [63:0] got, logic [63:0] exp);
        $display("FAIL %0t: record %0d field %s got %h expected %h",
                 $time, retired, field, got, exp);
        $display("sim failed");
        $fatal(1, "retire record mismatch");
    endtask

    task automatic compare_record(saturn_pkg::ret_t got, saturn_pkg::ret_t exp);
        assert (got.op == exp.op) else begin
            report_mismatch("op", 64'(got.op), 64'(exp.op));
        end
        assert (got.pc == exp.pc) else begin
            report_mismatch("pc", 64'(got.pc), 64'(exp.pc));
        end
        assert (got.value == exp.value) else begin
            report_mismatch("value", got.value, exp.value);
        end
        assert (got.next_pc == exp.next_pc) else begin
            report_mismatch("next_pc", 64'(got.next_pc), 64'(exp.next_pc));
        end
    endtask

    // ====================
    // stimulus and checking
    // ====================

    task automatic drive_nibbles();
        int idx;
        idx = 0;
        while (idx < nib_q.size()) begin
            @(posedge i_clk);
            #1;
            i_nib       = nib_q[idx];
            i_nib_valid = !rand_stall();
            // inputs are quiet until the next edge, so the handshake is read here.
            @(negedge i_clk);
            if (i_nib_valid && o_nib_ready) begin
                idx++;
            end
        end
        @(posedge i_clk);
        #1;
        i_nib_valid = 1'b0;
    endtask

    task automatic check_records();
        while (retired < exp_q.size()) begin
            @(posedge i_clk);
            #1;
            i_ret_ready = !rand_stall();
            @(negedge i_clk);
            if (o_ret_valid && i_ret_ready) begin
                compare_record(o_ret, exp_q[retired]);
                retired++;
            end
        end
        @(posedge i_clk);
        #1;
        i_ret_ready = 1'b1;
    endtask

    // no record may follow the last expected one.
    task automatic check_idle();
        repeat (10) begin
            @(negedge i_clk);
            assert (!o_ret_valid) else begin
                $display("an extra record retired after the last expected one");
                $display("sim failed");
                $fatal(1, "unexpected record");
            end
        end
    endtask

    initial begin
        i_reset       = 1'b1;
        i_nib         = '0;
        i_nib_valid   = 1'b0;
        i_ret_ready   = 1'b0;
        lcg_state     = 32'h4d2b_d6cc;
        pattern_lines = 0;
        retired       = 0;
        loaded        = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        fork
            drive_nibbles();
            check_records();
        join
        check_idle();
        if (exp_q.size() > 0 && retired == exp_q.size()) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("retired %0d records but expected %0d", retired, exp_q.size());
            $display("sim failed");
            $fatal(1, "record count mismatch");
        end
    end

    // watchdog, 40 cycles for each pattern line.
    initial begin
        wait (loaded);
        repeat (pattern_lines * 40) @(posedge i_clk);
        $display("timeout: retire stream stalled");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* saturn_patterns.txt */
# N: nibbles of one instruction in stream order, one hex digit per nibble.
# E: expected retire record as hex op code, pc, value and next_pc.
# register loads: P=E, LC 3 wrapping past nibble 15, C=P 5.
N 2e
E 05 00000 000000000000000e 00002
N 331234
E 06 00002 2100000000000043 00008
N 80c5
E 0a 00008 2100000000e00043 0000c
# immediates and jumps: D0=(5), GOVLNG, GOTO forward and backward.
N 1b54321
E 04 0000c 0000000000012345 00013
N 8d00123
E 0e 00013 0000000000000000 32100
N 6210
E 07 0001a 0000000000000000 0002d
N 60ff
E 07 0001e 0000000000000000 0000f
# subroutine call and returns, the second one on an empty stack.
N 8f00400
E 0f 00022 0000000000000000 00400
N 02
E 00 00029 0000000000000001 00029
N 03
E 01 0002b 0000000000000000 00000
# status bits, hardware status, mode and no-ops.
N 853
E 0d 0002d 0000000000000008 00030
N 85f
E 0d 00030 0000000000008008 00033
N 843
E 0c 00033 0000000000008000 00036
N 825
E 0b 00036 0000000000000000 00039
N 05
E 03 00039 0000000000000000 0003b
N 04
E 02 0003b 0000000000000001 0003d
N 805
E 08 0003d 0000000000000000 00040
N 80a
E 09 00040 0000000000000000 00043
# illegal opcodes, then a normal instruction.
N 7
E 10 00043 0000000000000000 00044
N 0f
E 10 00044 0000000000000000 00045
N 23
E 05 00046 0000000000000003 00048

/* verilog.f */
saturn_pkg.sv
saturn_decode.sv
saturn_exec.sv
saturn_retire.sv
saturn_core.sv
saturn_core_sva.sv
tb_saturn_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_saturn_core
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
